//--- hw/tiny45_pkg.sv
package tiny45_pkg;

    // Register file geometry, 16 for RV32E or 32 for full RV32I
    localparam int num_regs      = 16;
    localparam int reg_addr_bits = $clog2(num_regs);

    // One sub-cycle is eight clocks of four bits each
    localparam int counter_bits  = 3;

    typedef logic [3:0] nibble_t;

    // ALU operation code
    // Bit 3 selects subtract, bits 2:0 follow funct3
    // Bits 3:1 == 001 is set-less-than, bit 0 then selects unsigned
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t alu_add = 4'b0000;
    localparam alu_op_t alu_sub = 4'b1000;
    localparam alu_op_t alu_slt = 4'b0010;
    localparam alu_op_t alu_xor = 4'b0100;
    localparam alu_op_t alu_or  = 4'b0110;
    localparam alu_op_t alu_and = 4'b0111;

    // Supported RV32 major opcodes
    localparam logic [6:0] op_load    = 7'b0000011;
    localparam logic [6:0] op_store   = 7'b0100011;
    localparam logic [6:0] op_alu_imm = 7'b0010011;
    localparam logic [6:0] op_alu_reg = 7'b0110011;
    localparam logic [6:0] op_lui     = 7'b0110111;
    localparam logic [6:0] op_auipc   = 7'b0010111;

endpackage

//--- hw/tiny45_alu.sv
module tiny45_alu (
    input  tiny45_pkg::alu_op_t alu_op,
    input  tiny45_pkg::nibble_t a,
    input  tiny45_pkg::nibble_t b,
    input  logic                cy_in,
    input  logic                cmp_in,
    output tiny45_pkg::nibble_t result,
    output logic                cy_out,
    output logic                cmp_out
);
    import tiny45_pkg::*;

    nibble_t    b_eff;
    logic [4:0] sum;
    logic       is_slt;
    logic       lt_unsigned;

    assign is_slt = alu_op[3:1] == alu_slt[3:1];

    // Subtract is a + ~b with the carry chain seeded to one
    assign b_eff  = alu_op[3] ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_eff} + {4'b0000, cy_in};
    assign cy_out = sum[4];

    // Higher nibble decides, an equal nibble passes the lower verdict on
    assign lt_unsigned = (a < b) || ((a == b) && cmp_in);

    always_comb begin
        if (is_slt && !alu_op[0] && (a[3] != b[3])) begin
            cmp_out = a[3];                         // Signs differ, negative side is less
        end else begin
            cmp_out = lt_unsigned;
        end
    end

    always_comb begin
        case (alu_op[2:0])
            alu_xor[2:0]: result = a ^ b;
            alu_or[2:0]:  result = a | b;
            alu_and[2:0]: result = a & b;
            default:      result = sum[3:0];        // add, sub and address sums
        endcase
    end

endmodule

//--- hw/tiny45_registers.sv
module tiny45_registers #(
    parameter int num_regs = tiny45_pkg::num_regs
) (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic                                 wr_en,
    input  logic [tiny45_pkg::counter_bits-1:0]  counter,
    input  logic [tiny45_pkg::reg_addr_bits-1:0] rs1,
    input  logic [tiny45_pkg::reg_addr_bits-1:0] rs2,
    input  logic [tiny45_pkg::reg_addr_bits-1:0] rd,
    input  tiny45_pkg::nibble_t                  data_rd,
    output tiny45_pkg::nibble_t                  data_rs1,
    output tiny45_pkg::nibble_t                  data_rs2
);

    logic [31:0] regs [num_regs];
    logic        wr_pass;                           // A write pass is in progress
    logic        wr_ok;

    // A write must start on nibble 0 so that a whole word lands aligned
    assign wr_ok = wr_en && (counter == '0 || wr_pass);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_pass <= 1'b0;
        end else begin
            wr_pass <= wr_ok && counter != '1;
        end
    end

    // Every word rotates right one nibble per clock so that the bottom nibble
    // is always the one selected by counter
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            regs[0] <= '0;                          // x0 is hardwired zero
            for (int i = 1; i < num_regs; i++) begin
                if (wr_ok && int'(rd) == i) begin
                    regs[i] <= {data_rd, regs[i][31:4]};
                end else begin
                    regs[i] <= {regs[i][3:0], regs[i][31:4]};
                end
            end
        end
    end

    assign data_rs1 = regs[rs1][3:0];
    assign data_rs2 = regs[rs2][3:0];

endmodule

//--- hw/tiny45_decoder.sv
module tiny45_decoder (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic [31:0]                          instr,
    input  logic                                 instr_complete,
    output logic                                 is_load,
    output logic                                 is_store,
    output logic                                 is_alu_imm,
    output logic                                 is_alu_reg,
    output logic                                 is_lui,
    output logic                                 is_auipc,
    output tiny45_pkg::alu_op_t                  alu_op,
    output logic [tiny45_pkg::reg_addr_bits-1:0] rs1,
    output logic [tiny45_pkg::reg_addr_bits-1:0] rs2,
    output logic [tiny45_pkg::reg_addr_bits-1:0] rd,
    output logic [tiny45_pkg::counter_bits-1:0]  counter,
    output tiny45_pkg::nibble_t                  imm,
    output tiny45_pkg::nibble_t                  pc
);
    import tiny45_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [31:0] imm_word;
    logic [31:0] pc_word;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign is_load    = opcode == op_load;
    assign is_store   = opcode == op_store;
    assign is_alu_imm = opcode == op_alu_imm;
    assign is_alu_reg = opcode == op_alu_reg;
    assign is_lui     = opcode == op_lui;
    assign is_auipc   = opcode == op_auipc;

    // Upper index bits are dropped when running with 16 registers
    assign rs1 = instr[15 +: reg_addr_bits];
    assign rs2 = instr[20 +: reg_addr_bits];
    assign rd  = instr[7 +: reg_addr_bits];

    always_comb begin
        alu_op = alu_add;                           // Address and AUIPC sums
        if (is_alu_imm || is_alu_reg) begin
            alu_op = {1'b0, funct3};
            if (is_alu_reg && instr[30] && funct3 == 3'b000) begin
                alu_op = alu_sub;                   // Only R-type has a sub form
            end
        end
    end

    // I, S or U immediate, sign extended where the format asks for it
    always_comb begin
        if (is_store) begin
            imm_word = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        end else if (is_lui || is_auipc) begin
            imm_word = {instr[31:12], 12'h000};
        end else begin
            imm_word = {{20{instr[31]}}, instr[31:20]};
        end
    end

    assign imm = imm_word[{counter, 2'b00} +: 4];
    assign pc  = pc_word[{counter, 2'b00} +: 4];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;              // Free running, never stalls
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_word <= '0;
        end else if (instr_complete) begin
            pc_word <= pc_word + 32'd4;             // Retire moves to the next word
        end
    end

endmodule

//--- hw/tiny45_core.sv
module tiny45_core (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic                                 is_load,
    input  logic                                 is_store,
    input  logic                                 is_alu_imm,
    input  logic                                 is_alu_reg,
    input  logic                                 is_lui,
    input  logic                                 is_auipc,
    input  tiny45_pkg::alu_op_t                  alu_op,
    input  logic [tiny45_pkg::reg_addr_bits-1:0] rs1,
    input  logic [tiny45_pkg::reg_addr_bits-1:0] rs2,
    input  logic [tiny45_pkg::reg_addr_bits-1:0] rd,
    input  logic [tiny45_pkg::counter_bits-1:0]  counter,
    input  tiny45_pkg::nibble_t                  imm,
    input  tiny45_pkg::nibble_t                  pc,
    input  tiny45_pkg::nibble_t                  data_in,
    input  logic                                 load_data_ready,
    output logic [31:0]                          data_out,
    output logic                                 address_ready,
    output logic                                 store_data_ready,
    output logic                                 instr_complete
);
    import tiny45_pkg::*;

    nibble_t     data_rs1;
    nibble_t     data_rs2;
    nibble_t     data_rd;
    logic        wr_en;
    nibble_t     alu_a;
    nibble_t     alu_b;
    nibble_t     alu_out;
    alu_op_t     alu_op_slice;
    logic        cy;
    logic        cmp;
    logic        cy_in;
    logic        cmp_in;
    logic        cy_out;
    logic        cmp_out;
    logic        last_count;
    logic        is_alu;
    logic        is_slt;
    logic [1:0]  cycle;                             // Sub-cycle index, saturates
    logic        load_done;
    logic [31:0] out_word;
    nibble_t     shift_in;

    tiny45_registers #(.num_regs(num_regs)) u_registers (
        .clk      (clk),
        .rstn     (rstn),
        .wr_en    (wr_en),
        .counter  (counter),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .data_rd  (data_rd),
        .data_rs1 (data_rs1),
        .data_rs2 (data_rs2)
    );

    assign last_count = counter == '1;
    assign is_alu     = is_alu_imm || is_alu_reg;
    assign is_slt     = is_alu && alu_op[3:1] == alu_slt[3:1];

    assign alu_a  = is_auipc ? pc : data_rs1;
    assign alu_b  = is_alu_reg ? data_rs2 : imm;
    assign cy_in  = (counter == '0) ? alu_op[3] : cy;
    assign cmp_in = (counter == '0) ? 1'b0 : cmp;

    // Sign correction belongs to the top nibble only
    assign alu_op_slice = (is_slt && !last_count) ? {alu_op[3:1], 1'b1} : alu_op;

    tiny45_alu u_alu (
        .alu_op  (alu_op_slice),
        .a       (alu_a),
        .b       (alu_b),
        .cy_in   (cy_in),
        .cmp_in  (cmp_in),
        .result  (alu_out),
        .cy_out  (cy_out),
        .cmp_out (cmp_out)
    );

    always_ff @(posedge clk) begin
        cy  <= cy_out;
        cmp <= cmp_out;
    end

    always_comb begin
        wr_en   = 1'b0;
        data_rd = alu_out;
        if (is_slt) begin
            // Compare result is final at the start of sub-cycle 1
            wr_en   = cycle == 2'd1;
            data_rd = (counter == '0) ? {3'b000, cmp} : 4'h0;
        end else if (is_alu || is_auipc) begin
            wr_en = cycle == 2'd0;
        end else if (is_lui) begin
            wr_en   = cycle == 2'd0;
            data_rd = imm;
        end else if (is_load) begin
            wr_en   = load_data_ready && cycle != 2'd0;
            data_rd = data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cycle <= '0;
        end else if (last_count) begin
            if (instr_complete) begin
                cycle <= '0;
            end else if (cycle != 2'd3) begin
                cycle <= cycle + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            load_done <= 1'b0;
        end else if (counter == '0) begin
            load_done <= load_data_ready;           // Data window opens on nibble 0
        end
    end

    // Address on sub-cycle 0, store data on the following ones
    assign shift_in = (cycle == 2'd0) ? alu_out : data_rs2;

    always_ff @(posedge clk) begin
        out_word <= {shift_in, out_word[31:4]};
    end

    always_comb begin
        instr_complete = 1'b0;
        if (last_count) begin
            if (is_slt) begin
                instr_complete = cycle == 2'd1;
            end else if (is_alu || is_auipc || is_lui) begin
                instr_complete = 1'b1;
            end else if (is_store) begin
                instr_complete = cycle == 2'd1;
            end else if (is_load) begin
                instr_complete = load_done && cycle != 2'd0;
            end else begin
                instr_complete = 1'b1;              // Unknown opcode retires as a no-op
            end
        end
    end

    assign data_out         = out_word;
    assign address_ready    = last_count && cycle == 2'd0 && (is_load || is_store);
    assign store_data_ready = last_count && cycle == 2'd1 && is_store;

endmodule

//--- hw/tiny45_top.sv
module tiny45_top (
    input  logic                clk,
    input  logic                rstn,
    input  logic [31:0]         instr,
    input  tiny45_pkg::nibble_t data_in,
    input  logic                load_data_ready,
    output logic                instr_complete,
    output logic [31:0]         data_out,
    output logic                address_ready,
    output logic                store_data_ready
);
    import tiny45_pkg::*;

    logic                     is_load;
    logic                     is_store;
    logic                     is_alu_imm;
    logic                     is_alu_reg;
    logic                     is_lui;
    logic                     is_auipc;
    alu_op_t                  alu_op;
    logic [reg_addr_bits-1:0] rs1;
    logic [reg_addr_bits-1:0] rs2;
    logic [reg_addr_bits-1:0] rd;
    logic [counter_bits-1:0]  counter;
    nibble_t                  imm;
    nibble_t                  pc;

    tiny45_decoder u_decoder (
        .clk            (clk),
        .rstn           (rstn),
        .instr          (instr),
        .instr_complete (instr_complete),
        .is_load        (is_load),
        .is_store       (is_store),
        .is_alu_imm     (is_alu_imm),
        .is_alu_reg     (is_alu_reg),
        .is_lui         (is_lui),
        .is_auipc       (is_auipc),
        .alu_op         (alu_op),
        .rs1            (rs1),
        .rs2            (rs2),
        .rd             (rd),
        .counter        (counter),
        .imm            (imm),
        .pc             (pc)
    );

    tiny45_core u_core (
        .clk              (clk),
        .rstn             (rstn),
        .is_load          (is_load),
        .is_store         (is_store),
        .is_alu_imm       (is_alu_imm),
        .is_alu_reg       (is_alu_reg),
        .is_lui           (is_lui),
        .is_auipc         (is_auipc),
        .alu_op           (alu_op),
        .rs1              (rs1),
        .rs2              (rs2),
        .rd               (rd),
        .counter          (counter),
        .imm              (imm),
        .pc               (pc),
        .data_in          (data_in),
        .load_data_ready  (load_data_ready),
        .data_out         (data_out),
        .address_ready    (address_ready),
        .store_data_ready (store_data_ready),
        .instr_complete   (instr_complete)
    );

endmodule

//--- verification/tiny45_asserts.sv
module tiny45_core_asserts (
    input logic                                clk,
    input logic                                rstn,
    input logic [tiny45_pkg::counter_bits-1:0] counter,
    input logic                                is_load,
    input logic                                is_store,
    input logic                                load_data_ready,
    input logic                                instr_complete,
    input logic                                address_ready,
    input logic                                store_data_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // A store retires one sub-cycle after its address together with the data strobe
    store_retires: assert property (
        @(posedge clk) disable iff (!rstn)
        (address_ready && is_store) |-> ##8 (store_data_ready && instr_complete)
    ) else $error("store not retired with store_data_ready one sub-cycle after address");

    // Load data seen on nibble 0 ends the load on nibble 7
    load_retires: assert property (
        @(posedge clk) disable iff (!rstn)
        (is_load && load_data_ready && counter == '0) |-> ##7 instr_complete
    ) else $error("load not retired seven clocks after its data window opened");

    // Sub-cycle index advances so the address strobe is not repeated
    address_once: assert property (
        @(posedge clk) disable iff (!rstn)
        address_ready |-> ##8 !address_ready
    ) else $error("address_ready raised again one sub-cycle later");

endmodule

bind tiny45_core tiny45_core_asserts u_core_asserts (
    .clk              (clk),
    .rstn             (rstn),
    .counter          (counter),
    .is_load          (is_load),
    .is_store         (is_store),
    .load_data_ready  (load_data_ready),
    .instr_complete   (instr_complete),
    .address_ready    (address_ready),
    .store_data_ready (store_data_ready)
);

//--- verification/tiny45_tb.sv
module tiny45_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import tiny45_pkg::*;

    localparam int clk_period = 40;
    localparam int max_tests  = 64;

    logic        clk;
    logic        rstn;
    logic [31:0] instr;
    nibble_t     data_in;
    logic        load_data_ready;
    logic        instr_complete;
    logic [31:0] data_out;
    logic        address_ready;
    logic        store_data_ready;

    // Stimulus table with expected values
    logic [31:0] tbl_instr    [max_tests];
    string       tbl_name     [max_tests];
    logic [31:0] tbl_load     [max_tests];               // Word driven on data_in for a load
    logic [31:0] tbl_addr     [max_tests];
    logic [31:0] tbl_data     [max_tests];
    int          tbl_clocks   [max_tests];
    logic        tbl_has_addr [max_tests];
    logic        tbl_is_store [max_tests];
    int          n_tests;

    // Reference model state
    logic [31:0] ref_regs [num_regs];
    logic [31:0] ref_pc;

    int          seed;
    int          errors;
    int          test_errors;
    logic        mid_cycle;                              // Next instruction already at its first negedge

    tiny45_top dut (
        .clk              (clk),
        .rstn             (rstn),
        .instr            (instr),
        .data_in          (data_in),
        .load_data_ready  (load_data_ready),
        .instr_complete   (instr_complete),
        .data_out         (data_out),
        .address_ready    (address_ready),
        .store_data_ready (store_data_ready)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] enc_i(logic [6:0] op, int rd, logic [2:0] f3, int rs1,
                                          logic [11:0] imm);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                          int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op_alu_reg};
    endfunction

    function automatic logic [31:0] enc_s(int rs2, int rs1, logic [11:0] imm);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_u(logic [6:0] op, int rd, logic [19:0] imm);
        return {imm, 5'(rd), op};
    endfunction

    // Runs one instruction through the reference model and records what to expect
    task automatic add_test(input string name, input logic [31:0] ins,
                            input logic [31:0] load_word);
        logic [6:0]  op;
        logic [2:0]  f3;
        int          rd;
        int          rs1;
        int          rs2;
        int          k;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        wr;
        op  = ins[6:0];
        f3  = ins[14:12];
        rd  = int'(ins[11:7]) % num_regs;
        rs1 = int'(ins[19:15]) % num_regs;
        rs2 = int'(ins[24:20]) % num_regs;
        a   = ref_regs[rs1];
        b   = ref_regs[rs2];
        k   = n_tests;
        res = '0;
        wr  = 1'b0;
        tbl_name[k]     = name;
        tbl_instr[k]    = ins;
        tbl_load[k]     = load_word;
        tbl_addr[k]     = '0;
        tbl_data[k]     = '0;
        tbl_clocks[k]   = 8;
        tbl_has_addr[k] = 1'b0;
        tbl_is_store[k] = 1'b0;
        case (op)
            op_lui: begin
                res = {ins[31:12], 12'h000};
                wr  = 1'b1;
            end
            op_auipc: begin
                res = ref_pc + {ins[31:12], 12'h000};
                wr  = 1'b1;
            end
            op_alu_imm, op_alu_reg: begin
                if (op == op_alu_imm) begin
                    b = {{20{ins[31]}}, ins[31:20]};
                end
                wr = 1'b1;
                case (f3)
                    3'b000: res = (op == op_alu_reg && ins[30]) ? a - b : a + b;
                    3'b010: begin
                        res = {31'b0, $signed(a) < $signed(b)};
                        tbl_clocks[k] = 16;              // Compare needs a second pass
                    end
                    3'b011: begin
                        res = {31'b0, a < b};
                        tbl_clocks[k] = 16;
                    end
                    3'b100: res = a ^ b;
                    3'b110: res = a | b;
                    3'b111: res = a & b;
                    default: wr = 1'b0;
                endcase
            end
            op_load: begin
                tbl_addr[k]     = a + {{20{ins[31]}}, ins[31:20]};
                tbl_has_addr[k] = 1'b1;
                tbl_clocks[k]   = 16;
                res             = load_word;
                wr              = 1'b1;
            end
            op_store: begin
                tbl_addr[k]     = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                tbl_data[k]     = b;
                tbl_has_addr[k] = 1'b1;
                tbl_is_store[k] = 1'b1;
                tbl_clocks[k]   = 16;
            end
            default: ;
        endcase
        if (wr && rd != 0) begin
            ref_regs[rd] = res;
        end
        ref_pc  = ref_pc + 32'd4;
        n_tests = n_tests + 1;
    endtask

    task automatic read_back(input string name, input int rs);
        add_test(name, enc_s(rs, 0, 12'($random(seed))), '0);
    endtask

    task automatic build_table();
        add_test("lui", enc_u(op_lui, 1, 20'($random(seed))), '0);
        read_back("sw_lui", 1);
        add_test("lui_a", enc_u(op_lui, 4, 20'($random(seed))), '0);
        add_test("addi_a", enc_i(op_alu_imm, 4, 3'b000, 4, 12'($random(seed))), '0);
        add_test("lui_b", enc_u(op_lui, 5, 20'($random(seed))), '0);
        add_test("addi_b", enc_i(op_alu_imm, 5, 3'b000, 5, 12'($random(seed))), '0);
        add_test("add", enc_r(7'h00, 5, 4, 3'b000, 6), '0);
        read_back("sw_add", 6);
        add_test("sub", enc_r(7'h20, 5, 4, 3'b000, 7), '0);
        read_back("sw_sub", 7);
        add_test("and", enc_r(7'h00, 5, 4, 3'b111, 8), '0);
        read_back("sw_and", 8);
        add_test("or", enc_r(7'h00, 5, 4, 3'b110, 9), '0);
        read_back("sw_or", 9);
        add_test("xor", enc_r(7'h00, 5, 4, 3'b100, 10), '0);
        read_back("sw_xor", 10);
        add_test("xori", enc_i(op_alu_imm, 11, 3'b100, 4, 12'($random(seed))), '0);
        add_test("ori", enc_i(op_alu_imm, 12, 3'b110, 5, 12'($random(seed))), '0);
        add_test("andi", enc_i(op_alu_imm, 13, 3'b111, 6, 12'($random(seed))), '0);
        add_test("add_chain", enc_r(7'h00, 12, 11, 3'b000, 14), '0);
        add_test("sub_chain", enc_r(7'h20, 13, 14, 3'b000, 14), '0);
        read_back("sw_chain", 14);
        // Boundary operands of most negative, one and minus one
        add_test("lui_min", enc_u(op_lui, 12, 20'h80000), '0);
        add_test("li_one", enc_i(op_alu_imm, 13, 3'b000, 0, 12'h001), '0);
        add_test("li_m1", enc_i(op_alu_imm, 14, 3'b000, 0, 12'hfff), '0);
        add_test("slt_neg", enc_r(7'h00, 13, 12, 3'b010, 15), '0);
        read_back("sw_slt_neg", 15);
        add_test("sltu_neg", enc_r(7'h00, 13, 12, 3'b011, 15), '0);
        read_back("sw_sltu_neg", 15);
        add_test("slt_eq", enc_r(7'h00, 13, 13, 3'b010, 15), '0);
        read_back("sw_slt_eq", 15);
        add_test("slt_m1", enc_r(7'h00, 13, 14, 3'b010, 15), '0);
        read_back("sw_slt_m1", 15);
        add_test("sltu_m1", enc_r(7'h00, 13, 14, 3'b011, 15), '0);
        read_back("sw_sltu_m1", 15);
        add_test("slti", enc_i(op_alu_imm, 15, 3'b010, 14, 12'h000), '0);
        read_back("sw_slti", 15);
        add_test("sltiu", enc_i(op_alu_imm, 15, 3'b011, 13, 12'hfff), '0);
        read_back("sw_sltiu", 15);
        add_test("auipc", enc_u(op_auipc, 3, 20'($random(seed))), '0);
        read_back("sw_auipc", 3);
        add_test("lw", enc_i(op_load, 2, 3'b010, 4, 12'($random(seed))), 32'($random(seed)));
        read_back("sw_lw", 2);
    endtask

    task automatic check_word(input string name, input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("Error %s %s expected %h actual %h", name, what, exp, act);
            errors      = errors + 1;
            test_errors = test_errors + 1;
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            $display("Error %s %s expected %b actual %b", name, what, exp, act);
            errors      = errors + 1;
            test_errors = test_errors + 1;
        end
    endtask

    task automatic check_clocks(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Error %s clocks expected %0d actual %0d", name, exp, act);
            errors      = errors + 1;
            test_errors = test_errors + 1;
        end
    endtask

    // Samples at negedge, drives at posedge, returns on the retiring edge
    task automatic execute_instr(input string name, input logic [31:0] cur_ins,
                                 input logic [31:0] next_ins,
                                 input logic [31:0] load_word, output int clocks,
                                 output logic [31:0] addr, output logic [31:0] sdata,
                                 output logic saw_addr, output logic saw_data);
        logic done;
        logic ar;
        logic sdr;
        logic addr_pending;
        logic is_ld;
        int   ld_idx;
        clocks       = 0;
        done         = 1'b0;
        addr_pending = 1'b0;
        ld_idx       = 0;
        addr         = '0;
        sdata        = '0;
        saw_addr     = 1'b0;
        saw_data     = 1'b0;
        is_ld        = cur_ins[6:0] == op_load;
        while (!done) begin
            if (!mid_cycle) begin
                @(negedge clk);
            end
            mid_cycle = 1'b0;
            clocks    = clocks + 1;
            if (addr_pending) begin
                addr         = data_out;                // Address is complete one clock later
                addr_pending = 1'b0;
            end
            ar   = address_ready;
            sdr  = store_data_ready;
            done = instr_complete;
            if (clocks < 8) begin
                check_flag(name, "instr_complete", 1'b0, instr_complete);
                check_flag(name, "address_ready", 1'b0, address_ready);
                check_flag(name, "store_data_ready", 1'b0, store_data_ready);
            end
            @(posedge clk);
            if (ar) begin
                addr_pending = 1'b1;
                saw_addr     = 1'b1;
            end
            if (ar && is_ld) begin
                load_data_ready <= 1'b1;
                data_in         <= load_word[3:0];
                ld_idx = 1;
            end else if (ld_idx > 0 && ld_idx < 8) begin
                data_in <= load_word[ld_idx*4 +: 4];
                ld_idx = ld_idx + 1;
            end else if (ld_idx == 8) begin
                load_data_ready <= 1'b0;
                data_in         <= 4'h0;
                ld_idx = 0;
            end
            if (sdr) begin
                saw_data = 1'b1;
            end
        end
        instr <= next_ins;
        if (saw_data) begin
            @(negedge clk);
            sdata     = data_out;
            mid_cycle = 1'b1;
        end
    endtask

    initial begin
        wait (rstn === 1'b1);
        #(n_tests * 24 * clk_period);
        $display("Timeout: the run did not finish within %0d clocks", n_tests * 24);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int          clocks;
        logic [31:0] addr;
        logic [31:0] sdata;
        logic [31:0] next_ins;
        logic        saw_addr;
        logic        saw_data;
        seed            = 32'he84b26d3;
        errors          = 0;
        n_tests         = 0;
        mid_cycle       = 1'b0;
        ref_pc          = '0;
        rstn            = 1'b0;
        instr           = '0;
        data_in         = 4'h0;
        load_data_ready = 1'b0;
        for (int r = 0; r < num_regs; r++) begin
            ref_regs[r] = '0;
        end
        build_table();
        instr = tbl_instr[0];
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            test_errors = 0;
            next_ins = (i + 1 < n_tests) ? tbl_instr[i+1] : enc_i(op_alu_imm, 0, 3'b000, 0, 12'h0);
            execute_instr(tbl_name[i], tbl_instr[i], next_ins, tbl_load[i], clocks, addr, sdata,
                          saw_addr, saw_data);
            check_clocks(tbl_name[i], tbl_clocks[i], clocks);
            if (tbl_has_addr[i]) begin
                if (!saw_addr) begin
                    $display("%s: address_ready was never raised", tbl_name[i]);
                    errors      = errors + 1;
                    test_errors = test_errors + 1;
                end else begin
                    check_word(tbl_name[i], "address", tbl_addr[i], addr);
                end
            end else begin
                check_flag(tbl_name[i], "address_ready", 1'b0, saw_addr);
            end
            if (tbl_is_store[i]) begin
                if (!saw_data) begin
                    $display("%s: store_data_ready was never raised", tbl_name[i]);
                    errors      = errors + 1;
                    test_errors = test_errors + 1;
                end else begin
                    check_word(tbl_name[i], "store data", tbl_data[i], sdata);
                end
            end else begin
                check_flag(tbl_name[i], "store_data_ready", 1'b0, saw_data);
            end
            $display("%-12s %s", tbl_name[i], (test_errors == 0) ? "ok" : "mismatch");
        end
        $display("Tests run %0d, errors %0d", n_tests, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
hw/tiny45_pkg.sv
hw/tiny45_alu.sv
hw/tiny45_registers.sv
hw/tiny45_decoder.sv
hw/tiny45_core.sv
hw/tiny45_top.sv
verification/tiny45_asserts.sv
verification/tiny45_tb.sv

//--- Makefile
# Verilator flow for the tiny45 subsystem

VERILATOR ?= verilator
TOP       ?= tiny45_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Passes only when the pass line appears in the simulation output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)
